//--- Makefile
# Verilator build and run for the norm-check subsystem

SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := norm_check_tb
FILELIST  := build.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless the pass line appears"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- build.f
design/mldsa_params_pkg.sv
design/norm_check_defines_pkg.sv
design/norm_check_mem.sv
design/norm_check_ctrl.sv
design/norm_check_coeff_unit.sv
design/norm_check_top.sv
verif/norm_check_tb.sv

//--- design/mldsa_params_pkg.sv
// ML-DSA constants for the norm check; q fits in 24 bits, memory packs four coefficients per word
`default_nettype none

package mldsa_params_pkg;

    // Coefficient width, enough for any value in [0, q)
    localparam int unsigned coeff_width = 24;

    // Prime modulus
    localparam logic [coeff_width-1:0] mldsa_q = 24'd8380417;

    // Coefficients per polynomial
    localparam int unsigned mldsa_n = 256;

    // Vector lengths for the s1/z side and the s2/t0 side
    localparam int unsigned mldsa_l = 7;
    localparam int unsigned mldsa_k = 8;

    // Memory word layout, lane 0 in the low bits
    localparam int unsigned coeffs_per_word = 4;
    localparam int unsigned mem_data_width = coeff_width * coeffs_per_word;

    // Memory geometry
    localparam int unsigned mem_addr_width = 10;
    localparam int unsigned mem_depth = 1024;

endpackage

`default_nettype wire

//--- design/norm_check_coeff_unit.sv
// Four-lane bound check; inputs must be reduced into [0, q), result lands one cycle after ctrl_done
`timescale 1ns/10ps
`default_nettype none

module norm_check_coeff_unit
    import mldsa_params_pkg::*;
    import norm_check_defines_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,

    input  chk_norm_mode_t            mode,
    input  logic                      check_enable,
    input  logic                      ctrl_done,
    input  logic [mem_data_width-1:0] rd_data,

    output logic                      norm_check_done,
    output logic                      norm_check_invalid
);

    // Read data trails the command by one cycle
    logic data_valid;

    logic [coeff_width-1:0]     q_half;
    logic [coeff_width-1:0]     bound;
    logic [coeff_width-1:0]     lane_coeff [coeffs_per_word];
    logic [coeff_width-1:0]     lane_mag   [coeffs_per_word];
    logic [coeffs_per_word-1:0] lane_over;
    logic                       any_over;
    logic                       invalid_sticky;

    // (q-1)/2, above this a coefficient stands for a negative value
    assign q_half = (mldsa_q - 1'b1) >> 1;

    // Bound per mode
    always_comb begin
        case (mode)
            z_bound:   bound = coeff_width'(z_bound_limit);
            r0_bound:  bound = coeff_width'(r0_bound_limit);
            ct0_bound: bound = coeff_width'(ct0_bound_limit);
            default:   bound = coeff_width'(ct0_bound_limit);
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_valid <= 1'b0;
        end else if (zeroize) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= check_enable;
        end
    end

    // Centred magnitude and compare, one per lane
    for (genvar i = 0; i < coeffs_per_word; i++) begin : g_lane
        assign lane_coeff[i] = rd_data[i*coeff_width +: coeff_width];
        assign lane_mag[i]   = (lane_coeff[i] > q_half) ? (mldsa_q - lane_coeff[i])
                                                        : lane_coeff[i];
        // At the bound counts as a violation
        assign lane_over[i]  = data_valid && (lane_mag[i] >= bound);
    end

    assign any_over = |lane_over;

    // Sticky flag, cleared once the result is taken
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid_sticky <= 1'b0;
        end else if (zeroize) begin
            invalid_sticky <= 1'b0;
        end else if (ctrl_done) begin
            invalid_sticky <= 1'b0;
        end else if (any_over) begin
            invalid_sticky <= 1'b1;
        end
    end

    // Result register, final word folded in on ctrl_done
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            norm_check_done    <= 1'b0;
            norm_check_invalid <= 1'b0;
        end else if (zeroize) begin
            norm_check_done    <= 1'b0;
            norm_check_invalid <= 1'b0;
        end else begin
            norm_check_done <= ctrl_done;
            if (ctrl_done) begin
                norm_check_invalid <= invalid_sticky | any_over;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/norm_check_ctrl.sv
// Read sweep for one vector; assumes it sits in one contiguous range and mode and base stay stable
`timescale 1ns/10ps
`default_nettype none

module norm_check_ctrl
    import mldsa_params_pkg::*;
    import norm_check_defines_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,

    input  logic                      norm_check_enable,
    input  chk_norm_mode_t            mode,
    input  logic [mem_addr_width-1:0] mem_base_addr,

    output rw_cmd_e                   mem_rd_cmd,
    output logic [mem_addr_width-1:0] mem_rd_addr,
    output logic                      check_enable,
    output logic                      ctrl_done
);

    chk_read_state_e state_ps;
    chk_read_state_e state_ns;

    // Word offset from the base address
    logic [mem_addr_width-1:0] rd_offset;
    logic [mem_addr_width-1:0] last_offset;
    logic [3:0]                num_poly;

    logic incr_offset;
    logic last_word;

    // Polynomial count per mode
    always_comb begin
        case (mode)
            z_bound:   num_poly = 4'(mldsa_l);
            r0_bound:  num_poly = 4'(mldsa_k);
            ct0_bound: num_poly = 4'(mldsa_k);
            default:   num_poly = 4'(mldsa_k);
        endcase
    end

    // Offset of the last word of the last polynomial
    assign last_offset = mem_addr_width'(num_poly * words_per_poly - 1);
    assign last_word   = (rd_offset == last_offset);

    // Offset counter, wraps to zero after the final read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_offset <= '0;
        end else if (zeroize) begin
            rd_offset <= '0;
        end else if (incr_offset) begin
            rd_offset <= last_word ? '0 : rd_offset + 1'b1;
        end
    end

    // State register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_ps <= chk_idle;
        end else if (zeroize) begin
            state_ps <= chk_idle;
        end else begin
            state_ps <= state_ns;
        end
    end

    // Next state, start is ignored unless idle
    always_comb begin
        state_ns    = state_ps;
        incr_offset = 1'b0;
        case (state_ps)
            chk_idle: begin
                if (norm_check_enable) begin
                    state_ns = chk_rd_mem;
                end
            end
            chk_rd_mem: begin
                incr_offset = 1'b1;
                if (last_word) begin
                    state_ns = chk_done;
                end
            end
            chk_done: begin
                state_ns = chk_idle;
            end
            default: begin
                state_ns = chk_idle;
            end
        endcase
    end

    // One read per cycle while sweeping
    assign mem_rd_cmd  = (state_ps == chk_rd_mem) ? rw_read : rw_idle;
    assign mem_rd_addr = mem_base_addr + rd_offset;

    // Checker framing
    assign check_enable = (state_ps == chk_rd_mem);
    // Same cycle as the last read data
    assign ctrl_done    = (state_ps == chk_done);

endmodule

`default_nettype wire

//--- design/norm_check_defines_pkg.sv
// Norm-check modes, FSM states, read command codes and bounds; bounds are for the ML-DSA-87 set
`default_nettype none

package norm_check_defines_pkg;

    // Which bound to test, also sets the vector length
    typedef enum logic [1:0] {
        z_bound   = 2'd0,
        r0_bound  = 2'd1,
        ct0_bound = 2'd2
    } chk_norm_mode_t;

    // Read sweep FSM
    typedef enum logic [1:0] {
        chk_idle   = 2'd0,
        chk_rd_mem = 2'd1,
        chk_done   = 2'd2
    } chk_read_state_e;

    // Memory read port command
    typedef enum logic [1:0] {
        rw_idle = 2'd0,
        rw_read = 2'd1
    } rw_cmd_e;

    // gamma1 - beta
    localparam int unsigned z_bound_limit = 524168;

    // gamma2 - beta
    localparam int unsigned r0_bound_limit = 261768;

    // gamma2
    localparam int unsigned ct0_bound_limit = 261888;

    // 256 coefficients over four lanes
    localparam int unsigned words_per_poly = 64;

endpackage

`default_nettype wire

//--- design/norm_check_mem.sv
// Coefficient RAM, one read and one write port, read data registered and held between reads
`timescale 1ns/10ps
`default_nettype none

module norm_check_mem
    import mldsa_params_pkg::*;
    import norm_check_defines_pkg::*;
(
    input  logic                      clk,

    // Load port
    input  logic                      wr_en,
    input  logic [mem_addr_width-1:0] wr_addr,
    input  logic [mem_data_width-1:0] wr_data,

    // Read port
    input  rw_cmd_e                   rd_cmd,
    input  logic [mem_addr_width-1:0] rd_addr,
    output logic [mem_data_width-1:0] rd_data
);

    // Storage array
    logic [mem_data_width-1:0] mem [mem_depth];

    // Write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read, data valid the cycle after the command
    always_ff @(posedge clk) begin
        if (rd_cmd == rw_read) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- design/norm_check_top.sv
// Norm-check subsystem; load the memory only while idle, done is a single-cycle strobe
`timescale 1ns/10ps
`default_nettype none

module norm_check_top
    import mldsa_params_pkg::*;
    import norm_check_defines_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,

    input  logic                      norm_check_enable,
    input  chk_norm_mode_t            mode,
    input  logic [mem_addr_width-1:0] mem_base_addr,

    // Coefficient load
    input  logic                      mem_wr_en,
    input  logic [mem_addr_width-1:0] mem_wr_addr,
    input  logic [mem_data_width-1:0] mem_wr_data,

    output logic                      norm_check_done,
    output logic                      norm_check_invalid
);

    rw_cmd_e                   mem_rd_cmd;
    logic [mem_addr_width-1:0] mem_rd_addr;
    logic [mem_data_width-1:0] mem_rd_data;
    logic                      check_enable;
    logic                      ctrl_done;

    // Address sweep
    norm_check_ctrl u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .mem_base_addr     (mem_base_addr),
        .mem_rd_cmd        (mem_rd_cmd),
        .mem_rd_addr       (mem_rd_addr),
        .check_enable      (check_enable),
        .ctrl_done         (ctrl_done)
    );

    norm_check_mem u_mem (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_cmd  (mem_rd_cmd),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data)
    );

    // Lane checks and result
    norm_check_coeff_unit u_coeff (
        .clk                (clk),
        .reset_n            (reset_n),
        .zeroize            (zeroize),
        .mode               (mode),
        .check_enable       (check_enable),
        .ctrl_done          (ctrl_done),
        .rd_data            (mem_rd_data),
        .norm_check_done    (norm_check_done),
        .norm_check_invalid (norm_check_invalid)
    );

endmodule

`default_nettype wire

//--- verif/norm_check_tb.sv
// Needs assertions enabled in the simulator and runs for about 5500 clock cycles
`timescale 1ns/10ps
`default_nettype none

module norm_check_tb
    import mldsa_params_pkg::*;
    import norm_check_defines_pkg::*;
();

    logic                      clk;
    logic                      reset_n;
    logic                      zeroize;
    logic                      norm_check_enable;
    chk_norm_mode_t            mode;
    logic [mem_addr_width-1:0] mem_base_addr;
    logic                      mem_wr_en;
    logic [mem_addr_width-1:0] mem_wr_addr;
    logic [mem_data_width-1:0] mem_wr_data;
    logic                      norm_check_done;
    logic                      norm_check_invalid;

    // Mirror of every word written into the DUT memory
    logic [mem_data_width-1:0] model_mem [mem_depth];
    logic [31:0]               lfsr_state;
    int                        errors;
    int                        checks;
    int                        tests_run;
    int                        tests_failed;

    norm_check_top u_dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .zeroize            (zeroize),
        .norm_check_enable  (norm_check_enable),
        .mode               (mode),
        .mem_base_addr      (mem_base_addr),
        .mem_wr_en          (mem_wr_en),
        .mem_wr_addr        (mem_wr_addr),
        .mem_wr_data        (mem_wr_data),
        .norm_check_done    (norm_check_done),
        .norm_check_invalid (norm_check_invalid)
    );

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Galois LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // Coefficient in [0, q) whose centred magnitude is below limit
    function automatic logic [coeff_width-1:0] random_coeff(input int unsigned limit);
        logic [31:0] mag;
        mag = take_bits(20);
        // Rejection keeps the magnitude in range
        while (mag >= limit) begin
            mag = take_bits(20);
        end
        if (take_bits(1) == 32'd1 && mag != 0) begin
            return mldsa_q - coeff_width'(mag);
        end
        return coeff_width'(mag);
    endfunction

    // Values above (q-1)/2 stand for negatives
    function automatic int unsigned centred_mag(input logic [coeff_width-1:0] c);
        int unsigned cv;
        int unsigned qv;
        cv = 32'(c);
        qv = 32'(mldsa_q);
        return (cv > (qv - 1) / 2) ? qv - cv : cv;
    endfunction

    function automatic int unsigned bound_of(input chk_norm_mode_t m);
        case (m)
            z_bound:  return z_bound_limit;
            r0_bound: return r0_bound_limit;
            default:  return ct0_bound_limit;
        endcase
    endfunction

    // z covers L polynomials and r0 and ct0 cover K
    function automatic int words_of(input chk_norm_mode_t m);
        return (m == z_bound) ? mldsa_l * words_per_poly : mldsa_k * words_per_poly;
    endfunction

    // Any magnitude at or above the bound fails the vector
    function automatic logic expected_invalid(input chk_norm_mode_t m, input int base);
        logic        bad;
        int unsigned mag;
        bad = 1'b0;
        for (int w = 0; w < words_of(m); w++) begin
            for (int l = 0; l < coeffs_per_word; l++) begin
                mag = centred_mag(model_mem[base + w][l*coeff_width +: coeff_width]);
                if (mag >= bound_of(m)) begin
                    bad = 1'b1;
                end
            end
        end
        return bad;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // Write port stays enabled until release_write
    task automatic write_word(input int addr, input logic [mem_data_width-1:0] data);
        @(negedge clk);
        mem_wr_en       = 1'b1;
        mem_wr_addr     = mem_addr_width'(addr);
        mem_wr_data     = data;
        model_mem[addr] = data;
    endtask

    task automatic release_write();
        @(negedge clk);
        mem_wr_en = 1'b0;
    endtask

    task automatic fill_random(input int base, input int words, input int unsigned limit);
        logic [mem_data_width-1:0] word;
        for (int w = 0; w < words; w++) begin
            for (int l = 0; l < coeffs_per_word; l++) begin
                word[l*coeff_width +: coeff_width] = random_coeff(limit);
            end
            write_word(base + w, word);
        end
        release_write();
    endtask

    // Patch one lane of one word
    task automatic set_coeff(input int addr, input int lane, input logic [coeff_width-1:0] value);
        logic [mem_data_width-1:0] word;
        word = model_mem[addr];
        word[lane*coeff_width +: coeff_width] = value;
        write_word(addr, word);
        release_write();
    endtask

    // Strobe a run, wait for done, then watch a tail window for any further done
    task automatic run_check(input string name, input chk_norm_mode_t m, input int base,
                             input int strobe_again, input int tail);
        int   cycles;
        int   extra_done;
        logic exp_inv;
        exp_inv = expected_invalid(m, base);
        @(negedge clk);
        mode              = m;
        mem_base_addr     = mem_addr_width'(base);
        norm_check_enable = 1'b1;
        cycles            = 0;
        // Timeout well past the M+2 cycle latency
        do begin
            @(negedge clk);
            cycles++;
            norm_check_enable = (cycles == strobe_again);
        end while (!norm_check_done && cycles < words_of(m) + 50);
        if (!norm_check_done) begin
            $display("%s: norm_check_done never arrived before the timeout", name);
            errors++;
        end else begin
            check_value({name, " done latency"}, words_of(m) + 2, cycles);
            check_value({name, " invalid"}, int'(exp_inv), int'(norm_check_invalid));
            extra_done = 0;
            for (int i = 0; i < tail; i++) begin
                @(negedge clk);
                if (norm_check_done) begin
                    extra_done++;
                end
            end
            check_value({name, " done cycles after the pulse"}, 0, extra_done);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
    endtask

    initial begin
        int err0;
        int seen;
        lfsr_state        = 32'ha165;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        reset_n           = 1'b0;
        zeroize           = 1'b0;
        norm_check_enable = 1'b0;
        mode              = z_bound;
        mem_base_addr     = '0;
        mem_wr_en         = 1'b0;
        mem_wr_addr       = '0;
        mem_wr_data       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // All z magnitudes inside the bound and a 450 cycle latency
        err0 = errors;
        fill_random(0, words_of(z_bound), z_bound_limit);
        run_check("z_in_range", z_bound, 0, 0, 4);
        finish_test("z_in_range", err0);

        // Second strobe while busy must not start another run
        err0 = errors;
        run_check("z_restart_ignored", z_bound, 0, 100, words_of(z_bound) + 10);
        finish_test("z_restart_ignored", err0);

        // Violation in word 0 sets the sticky flag before zeroize cuts the run
        err0 = errors;
        set_coeff(0, 0, coeff_width'(z_bound_limit));
        @(negedge clk);
        mode              = z_bound;
        mem_base_addr     = '0;
        norm_check_enable = 1'b1;
        @(negedge clk);
        norm_check_enable = 1'b0;
        repeat (60) @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        seen = 0;
        for (int i = 0; i < 600; i++) begin
            @(negedge clk);
            if (norm_check_done) begin
                seen++;
            end
        end
        check_value("zeroize no done", 0, seen);
        // Repaired data must come back clean
        set_coeff(0, 0, '0);
        run_check("zeroize_clean_rerun", z_bound, 0, 0, 4);
        finish_test("zeroize_mid_run", err0);

        // Exactly at the r0 bound on the negative side in the last lane of the last word
        err0 = errors;
        fill_random(100, words_of(r0_bound), r0_bound_limit);
        set_coeff(100 + words_of(r0_bound) - 1, 3, mldsa_q - 24'd261768);
        run_check("r0_last_word", r0_bound, 100, 0, 4);
        finish_test("r0_last_word", err0);

        // ct0 edges with one below the bound on both sides and then one at the bound
        err0 = errors;
        fill_random(0, words_of(ct0_bound), ct0_bound_limit);
        set_coeff(10, 0, 24'd261887);
        set_coeff(20, 3, mldsa_q - 24'd261887);
        run_check("ct0_below_bound", ct0_bound, 0, 0, 4);
        set_coeff(300, 2, 24'd261888);
        run_check("ct0_at_bound", ct0_bound, 0, 0, 4);
        finish_test("ct0_edges", err0);

        $display("tests %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
